// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_decode_stage
FILELIST   := la_decode.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: la_decode.f
rtl/la_decode_pkg.sv
rtl/stage_fifo.sv
rtl/basic_decoder.sv
rtl/decoder.sv
rtl/decode_stage.sv
tests/tb_decode_stage.sv

// File: rtl/basic_decoder.sv
`timescale 1ns/1ps

module basic_decoder (
    input  logic [31:0]                 ins_i,
    output la_decode_pkg::decode_info_t decode_info_o
);
    import la_decode_pkg::*;

    decode_info_t info;
    logic         hit;  // word belongs to the supported subset

    always_comb begin
        info      = '0;
        info.inst = ins_i;
        hit       = 1'b1;
        unique case (ins_i[31:26])
            6'b000000: begin
                unique case (ins_i[25:22])
                    4'b0000: begin  // 3r format
                        info.reg_type_r0 = REG_RJ;
                        info.reg_type_r1 = REG_RK;
                        info.reg_type_w  = REG_W_RD;
                        unique case (ins_i[21:15])
                            7'h20:   info.alu_inst = ALU_ADD;
                            7'h22:   info.alu_inst = ALU_SUB;
                            7'h24:   info.alu_inst = ALU_SLT;
                            7'h25:   info.alu_inst = ALU_SLTU;
                            7'h29:   info.alu_inst = ALU_AND;
                            7'h2a:   info.alu_inst = ALU_OR;
                            7'h2b:   info.alu_inst = ALU_XOR;
                            7'h38:   info.mdu_inst = MDU_MUL;
                            7'h40:   info.mdu_inst = MDU_DIV;
                            default: hit = 1'b0;
                        endcase
                    end
                    4'b1010: begin  // addi.w
                        info.reg_type_r0 = REG_RJ;
                        info.reg_type_r1 = REG_IMM;
                        info.reg_type_w  = REG_W_RD;
                        info.imm_type    = IMM_SI12;
                        info.alu_inst    = ALU_ADD;
                    end
                    4'b1101: begin  // andi
                        info.reg_type_r0 = REG_RJ;
                        info.reg_type_r1 = REG_IMM;
                        info.reg_type_w  = REG_W_RD;
                        info.imm_type    = IMM_UI12;
                        info.alu_inst    = ALU_AND;
                    end
                    4'b1110: begin  // ori
                        info.reg_type_r0 = REG_RJ;
                        info.reg_type_r1 = REG_IMM;
                        info.reg_type_w  = REG_W_RD;
                        info.imm_type    = IMM_UI12;
                        info.alu_inst    = ALU_OR;
                    end
                    default: hit = 1'b0;
                endcase
            end
            6'b000101: begin
                // lu12i.w, rj field is part of si20
                hit              = !ins_i[25];
                info.reg_type_r1 = REG_IMM;
                info.reg_type_w  = REG_W_RD;
                info.imm_type    = IMM_SI20_HI;
                info.alu_inst    = ALU_LUI;
            end
            6'b001010: begin
                info.reg_type_r0   = REG_RJ;
                info.addr_imm_type = ADDR_SI12;
                unique case (ins_i[25:22])
                    4'b0010: begin  // ld.w
                        info.reg_type_w = REG_W_RD;
                        info.lsu_inst   = LSU_LDW;
                    end
                    4'b0110: begin  // st.w, data comes from rd
                        info.reg_type_r1 = REG_RD;
                        info.mem_write   = 1'b1;
                        info.lsu_inst    = LSU_STW;
                    end
                    default: hit = 1'b0;
                endcase
            end
            6'b010011: begin  // jirl
                info.reg_type_r0   = REG_RJ;
                info.reg_type_w    = REG_W_RD;
                info.addr_imm_type = ADDR_OFFS16;
                info.alu_inst      = ALU_JIRL;
            end
            6'b010100: begin
                info.addr_imm_type = ADDR_OFFS26;  // b
                info.alu_inst      = ALU_B;
            end
            6'b010101: begin
                info.reg_type_w    = REG_W_R1;  // bl links into r1
                info.addr_imm_type = ADDR_OFFS26;
                info.alu_inst      = ALU_BL;
            end
            6'b010110, 6'b010111: begin  // beq / bne
                info.reg_type_r0   = REG_RJ;
                info.reg_type_r1   = REG_RD;
                info.addr_imm_type = ADDR_OFFS16;
                info.alu_inst      = ins_i[26] ? ALU_BNE : ALU_BEQ;
            end
            default: hit = 1'b0;
        endcase
    end

    // unknown words decode as a no-op
    assign decode_info_o = hit ? info : '0;

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  la_decode_pkg::f_d_pkg_t in_data_i,
    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    output la_decode_pkg::d_r_pkg_t out_data_o
);
    import la_decode_pkg::*;

    logic     fd_valid;  // in_fifo -> decoder
    logic     fd_ready;
    f_d_pkg_t fd_data;
    logic     dr_valid;  // decoder -> out_fifo
    logic     dr_ready;
    d_r_pkg_t dr_data;

    stage_fifo #(.payload_t(f_d_pkg_t)) in_fifo (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .push_valid_i (in_valid_i),
        .push_ready_o (in_ready_o),
        .push_data_i  (in_data_i),
        .pop_valid_o  (fd_valid),
        .pop_ready_i  (fd_ready),
        .pop_data_o   (fd_data)
    );

    decoder u_decoder (
        .receiver_valid_i (fd_valid),
        .receiver_ready_o (fd_ready),
        .receiver_data_i  (fd_data),
        .sender_valid_o   (dr_valid),
        .sender_ready_i   (dr_ready),
        .sender_data_o    (dr_data)
    );

    stage_fifo #(.payload_t(d_r_pkg_t)) out_fifo (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .push_valid_i (dr_valid),
        .push_ready_o (dr_ready),
        .push_data_i  (dr_data),
        .pop_valid_o  (out_valid_o),
        .pop_ready_i  (out_ready_i),
        .pop_data_o   (out_data_o)
    );

endmodule

// File: rtl/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic                     receiver_valid_i,
    output logic                     receiver_ready_o,
    input  la_decode_pkg::f_d_pkg_t  receiver_data_i,
    output logic                     sender_valid_o,
    input  logic                     sender_ready_i,
    output la_decode_pkg::d_r_pkg_t  sender_data_o
);
    import la_decode_pkg::*;

    decode_info_t [DECODE_WIDTH-1:0] decode_infos;

    // purely combinational, handshake passes straight through
    assign sender_valid_o   = receiver_valid_i;
    assign receiver_ready_o = sender_ready_i;

    for (genvar i = 0; i < DECODE_WIDTH; i++) begin : g_lane
        basic_decoder u_basic_decoder (
            .ins_i         (receiver_data_i.insts[i]),
            .decode_info_o (decode_infos[i])
        );
    end

    // zero and imm roles both read gr0
    function automatic logic [4:0] src_arfid(input reg_type_r_t role, input logic [31:0] inst);
        case (role)
            REG_RD:  return inst[4:0];
            REG_RJ:  return inst[9:5];
            REG_RK:  return inst[14:10];
            default: return 5'd0;
        endcase
    endfunction

    function automatic logic [4:0] dst_arfid(input reg_type_w_t role, input logic [31:0] inst);
        case (role)
            REG_W_RD: return inst[4:0];
            REG_W_RJ: return inst[9:5];
            REG_W_R1: return 5'd1;
            default:  return 5'd0;  // no write lands on gr0
        endcase
    endfunction

    always_comb begin
        sender_data_o               = '0;
        sender_data_o.r_valid       = receiver_data_i.mask;
        sender_data_o.pc            = receiver_data_i.pc;
        sender_data_o.predict_infos = receiver_data_i.predict_infos;
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            sender_data_o.w_reg[i] = decode_infos[i].reg_type_w != REG_W_NONE;
            sender_data_o.w_mem[i] = decode_infos[i].mem_write;

            sender_data_o.reg_need[2*i]   =
                !(decode_infos[i].reg_type_r0 inside {REG_ZERO, REG_IMM});
            sender_data_o.reg_need[2*i+1] =
                !(decode_infos[i].reg_type_r1 inside {REG_ZERO, REG_IMM});
            sender_data_o.use_imm[2*i]    = decode_infos[i].reg_type_r0 == REG_IMM;
            sender_data_o.use_imm[2*i+1]  = decode_infos[i].reg_type_r1 == REG_IMM;

            sender_data_o.alu_type[i] = decode_infos[i].alu_inst;
            sender_data_o.mdu_type[i] = decode_infos[i].mdu_inst;
            sender_data_o.lsu_type[i] = decode_infos[i].lsu_inst;

            sender_data_o.arf_table.r_arfid[2*i] =
                src_arfid(decode_infos[i].reg_type_r0, decode_infos[i].inst);
            sender_data_o.arf_table.r_arfid[2*i+1] =
                src_arfid(decode_infos[i].reg_type_r1, decode_infos[i].inst);
            sender_data_o.arf_table.w_arfid[i] =
                dst_arfid(decode_infos[i].reg_type_w, decode_infos[i].inst);

            sender_data_o.data_imm[i] =
                inst_to_data_imm(decode_infos[i].inst, decode_infos[i].imm_type);
            sender_data_o.addr_imm[i] =
                inst_to_addr_imm(decode_infos[i].inst, decode_infos[i].addr_imm_type);
        end
    end

    // an imm source needs a data immediate kind from the basic decoder
    always_comb begin
        if (receiver_valid_i) begin
            for (int i = 0; i < DECODE_WIDTH; i++) begin
                a_imm_has_kind: assert final (!sender_data_o.use_imm[2*i+1]
                                              || decode_infos[i].imm_type != IMM_NONE);
            end
        end
    end

endmodule

// File: rtl/la_decode_pkg.sv
package la_decode_pkg;

    localparam int DECODE_WIDTH = 2;  // instructions per packet
    localparam int FIFO_DEPTH   = 2;  // entries per stage buffer
    localparam int FIFO_PTR_W   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int FIFO_CNT_W   = $clog2(FIFO_DEPTH + 1);

    // source operand role
    typedef enum logic [2:0] {
        REG_ZERO,
        REG_RD,
        REG_RJ,
        REG_RK,
        REG_IMM
    } reg_type_r_t;

    // destination role, R1 only for bl
    typedef enum logic [1:0] {
        REG_W_NONE,
        REG_W_RD,
        REG_W_RJ,
        REG_W_R1
    } reg_type_w_t;

    typedef enum logic [1:0] {
        IMM_NONE,
        IMM_SI12,
        IMM_UI12,
        IMM_SI20_HI
    } imm_type_t;

    typedef enum logic [1:0] {
        ADDR_NONE,
        ADDR_SI12,
        ADDR_OFFS16,
        ADDR_OFFS26
    } addr_imm_type_t;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_LUI, ALU_BEQ, ALU_BNE, ALU_B, ALU_BL, ALU_JIRL
    } alu_type_t;

    typedef enum logic [1:0] {MDU_NONE, MDU_MUL, MDU_DIV} mdu_type_t;
    typedef enum logic [1:0] {LSU_NONE, LSU_LDW, LSU_STW} lsu_type_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } predict_info_t;

    // fetch -> decode
    typedef struct packed {
        logic [DECODE_WIDTH-1:0]        mask;
        logic [DECODE_WIDTH-1:0][31:0]  pc;
        logic [DECODE_WIDTH-1:0][31:0]  insts;
        predict_info_t [DECODE_WIDTH-1:0] predict_infos;
    } f_d_pkg_t;

    typedef struct packed {
        logic [31:0]    inst;
        reg_type_r_t    reg_type_r0;
        reg_type_r_t    reg_type_r1;
        reg_type_w_t    reg_type_w;
        logic           mem_write;
        imm_type_t      imm_type;
        addr_imm_type_t addr_imm_type;
        alu_type_t      alu_inst;
        mdu_type_t      mdu_inst;
        lsu_type_t      lsu_inst;
    } decode_info_t;

    typedef struct packed {
        logic [2*DECODE_WIDTH-1:0][4:0] r_arfid;  // two sources per lane
        logic [DECODE_WIDTH-1:0][4:0]   w_arfid;
    } arf_table_t;

    // decode -> rename
    typedef struct packed {
        logic [DECODE_WIDTH-1:0]          r_valid;
        logic [DECODE_WIDTH-1:0][31:0]    pc;
        predict_info_t [DECODE_WIDTH-1:0] predict_infos;
        logic [DECODE_WIDTH-1:0]          w_reg;
        logic [DECODE_WIDTH-1:0]          w_mem;
        logic [2*DECODE_WIDTH-1:0]        reg_need;
        logic [2*DECODE_WIDTH-1:0]        use_imm;
        alu_type_t [DECODE_WIDTH-1:0]     alu_type;
        mdu_type_t [DECODE_WIDTH-1:0]     mdu_type;
        lsu_type_t [DECODE_WIDTH-1:0]     lsu_type;
        arf_table_t                       arf_table;
        logic [DECODE_WIDTH-1:0][31:0]    data_imm;
        logic [DECODE_WIDTH-1:0][31:0]    addr_imm;
    } d_r_pkg_t;

    function automatic logic [31:0] inst_to_data_imm(input logic [31:0] inst,
                                                     input imm_type_t  kind);
        case (kind)
            IMM_SI12:    return {{20{inst[21]}}, inst[21:10]};
            IMM_UI12:    return {20'b0, inst[21:10]};
            IMM_SI20_HI: return {inst[24:5], 12'b0};  // lu12i.w upper bits
            default:     return 32'b0;
        endcase
    endfunction

    function automatic logic [31:0] inst_to_addr_imm(input logic [31:0]    inst,
                                                     input addr_imm_type_t kind);
        case (kind)
            ADDR_SI12:   return {{20{inst[21]}}, inst[21:10]};
            ADDR_OFFS16: return {{14{inst[25]}}, inst[25:10], 2'b00};
            // offs26 keeps its high part in bits 9..0
            ADDR_OFFS26: return {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
            default:     return 32'b0;
        endcase
    endfunction

endpackage

// File: rtl/stage_fifo.sv
`timescale 1ns/1ps

module stage_fifo #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     push_valid_i,
    output logic     push_ready_o,
    input  payload_t push_data_i,
    output logic     pop_valid_o,
    input  logic     pop_ready_i,
    output payload_t pop_data_o
);
    import la_decode_pkg::*;

    payload_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  full;
    logic                  push_fire;
    logic                  pop_fire;

    function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
        return (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full         = count == FIFO_CNT_W'(FIFO_DEPTH);
    assign push_ready_o = !full || pop_ready_i;  // full buffer still takes one on a pop
    assign pop_valid_o  = count != '0;
    assign pop_data_o   = mem[rd_ptr];
    assign push_fire    = push_valid_i && push_ready_o;
    assign pop_fire     = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) wr_ptr <= next_ptr(wr_ptr);
            if (pop_fire)  rd_ptr <= next_ptr(rd_ptr);
            if (push_fire && !pop_fire) count <= count + 1'b1;
            else if (pop_fire && !push_fire) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) mem[wr_ptr] <= push_data_i;
    end

    // a write into a full buffer would carry count past the depth
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        count <= FIFO_CNT_W'(FIFO_DEPTH));

    // stalled head stays put until it is taken
    a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n_i)
        pop_valid_o && !pop_ready_i |=> pop_valid_o && $stable(pop_data_o));

endmodule

// File: tests/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;
    import la_decode_pkg::*;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 10;
    localparam int          NUM_TESTS    = 5;
    localparam int          CYCLE_LIMIT  = NUM_TESTS * 200 + 100;  // reset and drain margin
    localparam int          WAIT_LIMIT   = 10;
    localparam int          BP_PACKETS   = 20;
    localparam logic [31:0] SEED         = 32'hd566_522b;

    // instruction kinds the stimulus knows how to encode
    typedef enum int {
        K_ADD, K_SUB, K_SLT, K_SLTU, K_AND, K_OR, K_XOR, K_ADDI, K_ANDI, K_ORI, K_LU12I,
        K_MUL, K_DIV, K_LDW, K_STW, K_BEQ, K_BNE, K_B, K_BL, K_JIRL, K_UNK
    } kind_t;

    logic     clk;
    logic     rst_n_i;
    logic     in_valid_i;
    logic     in_ready_o;
    f_d_pkg_t in_data_i;
    logic     out_valid_o;
    logic     out_ready_i;
    d_r_pkg_t out_data_o;

    int checks = 0;
    int errors = 0;
    int cycles = 0;

    decode_stage dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (in_data_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] encode(input kind_t k, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk,
                                           input logic [25:0] imm);
        case (k)
            K_ADD:   return {17'h00020, rk, rj, rd};
            K_SUB:   return {17'h00022, rk, rj, rd};
            K_SLT:   return {17'h00024, rk, rj, rd};
            K_SLTU:  return {17'h00025, rk, rj, rd};
            K_AND:   return {17'h00029, rk, rj, rd};
            K_OR:    return {17'h0002a, rk, rj, rd};
            K_XOR:   return {17'h0002b, rk, rj, rd};
            K_MUL:   return {17'h00038, rk, rj, rd};
            K_DIV:   return {17'h00040, rk, rj, rd};
            K_ADDI:  return {10'h00a, imm[11:0], rj, rd};
            K_ANDI:  return {10'h00d, imm[11:0], rj, rd};
            K_ORI:   return {10'h00e, imm[11:0], rj, rd};
            K_LDW:   return {10'h0a2, imm[11:0], rj, rd};
            K_STW:   return {10'h0a6, imm[11:0], rj, rd};
            K_LU12I: return {7'h0a, imm[19:0], rd};
            K_JIRL:  return {6'h13, imm[15:0], rj, rd};
            K_BEQ:   return {6'h16, imm[15:0], rj, rd};
            K_BNE:   return {6'h17, imm[15:0], rj, rd};
            K_B:     return {6'h14, imm[15:0], imm[25:16]};  // offs26 split low/high
            K_BL:    return {6'h15, imm[15:0], imm[25:16]};
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic alu_type_t expected_alu(input kind_t k);
        case (k)
            K_ADD, K_ADDI: return ALU_ADD;
            K_SUB:         return ALU_SUB;
            K_SLT:         return ALU_SLT;
            K_SLTU:        return ALU_SLTU;
            K_AND, K_ANDI: return ALU_AND;
            K_OR, K_ORI:   return ALU_OR;
            K_XOR:         return ALU_XOR;
            K_LU12I:       return ALU_LUI;
            K_BEQ:         return ALU_BEQ;
            K_BNE:         return ALU_BNE;
            K_B:           return ALU_B;
            K_BL:          return ALU_BL;
            K_JIRL:        return ALU_JIRL;
            default:       return ALU_NONE;
        endcase
    endfunction

    function automatic f_d_pkg_t make_pkt(input kind_t k0, input logic [25:0] imm0,
                                          input kind_t k1, input logic [25:0] imm1,
                                          input logic [1:0] mask);
        f_d_pkg_t p;
        p                  = '0;
        p.mask             = mask;
        p.pc[0]            = $urandom & 32'hffff_fffc;
        p.pc[1]            = p.pc[0] + 32'd4;
        p.insts[0]         = encode(k0, 5'($urandom), 5'($urandom), 5'($urandom), imm0);
        p.insts[1]         = encode(k1, 5'($urandom), 5'($urandom), 5'($urandom), imm1);
        p.predict_infos[0] = {1'($urandom), 32'($urandom)};
        p.predict_infos[1] = {1'($urandom), 32'($urandom)};
        return p;
    endfunction

    // expected rename packet, worked out from the kind of each lane
    task automatic build_expected(input f_d_pkg_t p, input kind_t k0, input kind_t k1,
                                  output d_r_pkg_t e);
        kind_t       k;
        logic [31:0] w;
        logic        need0, need1, imm1, wr;
        logic [4:0]  id0, id1, wid;
        e               = '0;
        e.r_valid       = p.mask;
        e.pc            = p.pc;
        e.predict_infos = p.predict_infos;
        for (int i = 0; i < DECODE_WIDTH; i++) begin
            k = (i == 0) ? k0 : k1;
            w = p.insts[i];
            {need0, need1, imm1, wr} = '0;
            {id0, id1, wid} = '0;
            case (k)
                K_ADD, K_SUB, K_SLT, K_SLTU, K_AND, K_OR, K_XOR, K_MUL, K_DIV: begin
                    {need0, id0, need1, id1} = {1'b1, w[9:5], 1'b1, w[14:10]};
                    {wr, wid} = {1'b1, w[4:0]};
                end
                K_ADDI, K_ANDI, K_ORI: begin
                    {need0, id0, imm1} = {1'b1, w[9:5], 1'b1};
                    {wr, wid} = {1'b1, w[4:0]};
                    e.data_imm[i] = (k == K_ADDI) ? {{20{w[21]}}, w[21:10]} : {20'b0, w[21:10]};
                end
                K_LU12I: begin
                    imm1 = 1'b1;
                    {wr, wid} = {1'b1, w[4:0]};
                    e.data_imm[i] = {w[24:5], 12'b0};
                end
                K_LDW, K_STW: begin
                    {need0, id0} = {1'b1, w[9:5]};
                    e.addr_imm[i] = {{20{w[21]}}, w[21:10]};
                    e.w_mem[i] = (k == K_STW);
                    if (k == K_LDW) begin
                        {wr, wid} = {1'b1, w[4:0]};
                        e.lsu_type[i] = LSU_LDW;
                    end else begin
                        {need1, id1} = {1'b1, w[4:0]};  // store data
                        e.lsu_type[i] = LSU_STW;
                    end
                end
                K_BEQ, K_BNE, K_JIRL: begin
                    {need0, id0} = {1'b1, w[9:5]};
                    e.addr_imm[i] = {{14{w[25]}}, w[25:10], 2'b00};
                    if (k == K_JIRL) {wr, wid} = {1'b1, w[4:0]};
                    else {need1, id1} = {1'b1, w[4:0]};
                end
                K_B, K_BL: begin
                    e.addr_imm[i] = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
                    if (k == K_BL) {wr, wid} = {1'b1, 5'd1};  // link register
                end
                default: ;
            endcase
            e.alu_type[i] = expected_alu(k);
            if (k == K_MUL) e.mdu_type[i] = MDU_MUL;
            if (k == K_DIV) e.mdu_type[i] = MDU_DIV;
            e.reg_need[2*i]               = need0;
            e.reg_need[2*i+1]             = need1;
            e.use_imm[2*i+1]              = imm1;
            e.w_reg[i]                    = wr;
            e.arf_table.r_arfid[2*i]      = id0;
            e.arf_table.r_arfid[2*i+1]    = id1;
            e.arf_table.w_arfid[i]        = wid;
        end
    endtask

    function automatic bit field_differs(input string ctx, input string field,
                                         input logic [95:0] got, input logic [95:0] exp);
        if (got !== exp) begin
            $display("FAILED %s.%s: got %0h expected %0h", ctx, field, got, exp);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic check_pkg(input string ctx, input d_r_pkg_t got, input d_r_pkg_t exp);
        bit bad;
        checks++;
        bad = 1'b0;
        bad |= field_differs(ctx, "r_valid", 96'(got.r_valid), 96'(exp.r_valid));
        bad |= field_differs(ctx, "pc", 96'(got.pc), 96'(exp.pc));
        bad |= field_differs(ctx, "predict_infos", 96'(got.predict_infos),
                             96'(exp.predict_infos));
        bad |= field_differs(ctx, "w_reg", 96'(got.w_reg), 96'(exp.w_reg));
        bad |= field_differs(ctx, "w_mem", 96'(got.w_mem), 96'(exp.w_mem));
        bad |= field_differs(ctx, "reg_need", 96'(got.reg_need), 96'(exp.reg_need));
        bad |= field_differs(ctx, "use_imm", 96'(got.use_imm), 96'(exp.use_imm));
        bad |= field_differs(ctx, "alu_type", 96'(got.alu_type), 96'(exp.alu_type));
        bad |= field_differs(ctx, "mdu_type", 96'(got.mdu_type), 96'(exp.mdu_type));
        bad |= field_differs(ctx, "lsu_type", 96'(got.lsu_type), 96'(exp.lsu_type));
        bad |= field_differs(ctx, "r_arfid", 96'(got.arf_table.r_arfid),
                             96'(exp.arf_table.r_arfid));
        bad |= field_differs(ctx, "w_arfid", 96'(got.arf_table.w_arfid),
                             96'(exp.arf_table.w_arfid));
        bad |= field_differs(ctx, "data_imm", 96'(got.data_imm), 96'(exp.data_imm));
        bad |= field_differs(ctx, "addr_imm", 96'(got.addr_imm), 96'(exp.addr_imm));
        if (bad) errors++;
    endtask

    // holds valid and data until the edge that takes the packet
    task automatic push_pkt(input f_d_pkg_t p);
        bit done;
        done = 1'b0;
        @(negedge clk);
        in_valid_i = 1'b1;
        in_data_i  = p;
        while (!done) begin
            #1;
            if (in_ready_o) begin
                @(posedge clk);
                done = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic expect_output(input string ctx, input d_r_pkg_t exp);
        int waited;
        waited = 0;
        #1;
        while (!out_valid_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!out_valid_o) begin
            checks++;
            errors++;
            $display("%s: no output packet arrived within %0d cycles", ctx, WAIT_LIMIT);
        end else begin
            check_pkg(ctx, out_data_o, exp);
        end
        @(posedge clk);  // taken by rename, out_ready_i is high
    endtask

    task automatic send_pair(input string ctx, input kind_t k0, input logic [25:0] imm0,
                             input kind_t k1, input logic [25:0] imm1, input logic [1:0] mask);
        f_d_pkg_t p;
        d_r_pkg_t e;
        p = make_pkt(k0, imm0, k1, imm1, mask);
        build_expected(p, k0, k1, e);
        push_pkt(p);
        @(negedge clk);
        in_valid_i = 1'b0;
        expect_output(ctx, e);
    endtask

    task automatic log_result(input string name, input int errors_before);
        if (errors == errors_before) $display("test %s: ok", name);
        else $display("test %s: %0d failed checks", name, errors - errors_before);
    endtask

    task automatic reset_state_test();
        int e0;
        e0 = errors;
        @(negedge clk);
        #1;
        check_bit("out_valid_o after reset", out_valid_o, 1'b0);
        check_bit("in_ready_o after reset", in_ready_o, 1'b1);
        log_result("reset_state", e0);
    endtask

    task automatic alu_forms_test();
        int       e0;
        f_d_pkg_t p;
        d_r_pkg_t e;
        e0 = errors;
        p  = make_pkt(K_ADD, 26'h0, K_ADDI, 26'hf9c, 2'b11);  // addi -100
        build_expected(p, K_ADD, K_ADDI, e);
        push_pkt(p);
        @(negedge clk);
        in_valid_i = 1'b0;
        #1;
        check_bit("out_valid_o ahead of edge N+1", out_valid_o, 1'b0);
        @(negedge clk);
        #1;
        check_bit("out_valid_o ahead of edge N+2", out_valid_o, 1'b1);
        check_pkg("add/addi", out_data_o, e);
        @(posedge clk);
        send_pair("sub/andi", K_SUB, 26'h0, K_ANDI, 26'habc, 2'b11);
        send_pair("slt/ori", K_SLT, 26'h0, K_ORI, 26'hfff, 2'b11);
        send_pair("sltu/lu12i", K_SLTU, 26'h0, K_LU12I, 26'h8_1234, 2'b11);
        send_pair("and/or", K_AND, 26'h0, K_OR, 26'h0, 2'b11);
        send_pair("xor/addi", K_XOR, 26'h0, K_ADDI, 26'h7ff, 2'b11);
        log_result("alu_forms", e0);
    endtask

    task automatic mem_branch_test();
        int e0;
        e0 = errors;
        send_pair("ld/st", K_LDW, 26'h800, K_STW, 26'h7fc, 2'b11);
        send_pair("beq/bne", K_BEQ, 26'h8000, K_BNE, 26'h0010, 2'b11);
        send_pair("b/bl", K_B, 26'h200_0001, K_BL, 26'h0040, 2'b11);
        send_pair("jirl/ld", K_JIRL, 26'hfffc, K_LDW, 26'h004, 2'b11);
        log_result("mem_branch", e0);
    endtask

    task automatic mdu_mask_test();
        int e0;
        e0 = errors;
        send_pair("mul/div", K_MUL, 26'h0, K_DIV, 26'h0, 2'b11);
        send_pair("mul/unknown", K_MUL, 26'h0, K_UNK, 26'h0, 2'b01);
        send_pair("unknown/addi", K_UNK, 26'h0, K_ADDI, 26'h123, 2'b10);
        send_pair("empty mask", K_JIRL, 26'h10, K_BL, 26'h3, 2'b00);
        log_result("mdu_mask", e0);
    endtask

    task automatic backpressure_test();
        f_d_pkg_t pkts [BP_PACKETS];
        d_r_pkg_t exps [BP_PACKETS];
        kind_t    k0;
        kind_t    k1;
        int       e0;
        int       got;
        int       slots;
        bit       full_seen;
        bit       held;
        e0        = errors;
        got       = 0;
        slots     = 0;
        full_seen = 1'b0;
        held      = 1'b0;
        for (int n = 0; n < BP_PACKETS; n++) begin
            k0      = kind_t'($urandom_range(0, int'(K_UNK)));
            k1      = kind_t'($urandom_range(0, int'(K_UNK)));
            pkts[n] = make_pkt(k0, 26'($urandom), k1, 26'($urandom), 2'($urandom));
            build_expected(pkts[n], k0, k1, exps[n]);
        end
        fork
            begin
                for (int n = 0; n < BP_PACKETS; n++) push_pkt(pkts[n]);
                @(negedge clk);
                in_valid_i = 1'b0;
            end
            begin
                while (got < BP_PACKETS) begin
                    @(negedge clk);
                    // stall first so both buffers fill up
                    out_ready_i = (slots < 8) ? 1'b0 : 1'($urandom_range(0, 1));
                    slots++;
                    #1;
                    if (!in_ready_o) full_seen = 1'b1;
                    if (held) check_bit("out_valid_o held while stalled", out_valid_o, 1'b1);
                    if (out_valid_o) check_pkg($sformatf("packet %0d", got), out_data_o, exps[got]);
                    held = out_valid_o && !out_ready_i;
                    if (out_valid_o && out_ready_i) got++;
                end
            end
        join
        @(negedge clk);
        out_ready_i = 1'b1;
        repeat (3) @(negedge clk);
        #1;
        check_bit("out_valid_o after last packet", out_valid_o, 1'b0);
        check_bit("in_ready_o low once buffers filled", full_seen, 1'b1);
        log_result("backpressure", e0);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_data_i   = '0;
        out_ready_i = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
        reset_state_test();
        alu_forms_test();
        mem_branch_test();
        mdu_mask_test();
        backpressure_test();
        $display("summary: %0d tests, %0d checks, %0d failed", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
